//--- build.f
+incdir+include
rtl/streamBufferPkg.sv
rtl/fifoIf.sv
rtl/simpleDualPortMemory.sv
rtl/singleClockFifo.sv
rtl/writeGuard.sv
rtl/readStage.sv
rtl/streamBuffer.sv
tb/streamBufferTb.sv

//--- include/streamBuffer_defs.svh
`ifndef STREAMBUFFER_DEFS_SVH
`define STREAMBUFFER_DEFS_SVH

// width of one stored word
`define STREAMBUFFER_DATAWIDTH 8

// memory entries, one stays unused so the buffer holds depth-1 words
`define STREAMBUFFER_DEPTH 16

`define STREAMBUFFER_ADDRWIDTH $clog2(`STREAMBUFFER_DEPTH)

// drop and underflow counters
`define STREAMBUFFER_COUNTWIDTH 8

`endif

//--- rtl/fifoIf.sv
interface fifoIf
    import streamBufferPkg::*;
    ();

    logic                       writeEn;    // from write guard
    dataWord                    dataIn;
    logic                       readReq;    // from read stage
    dataWord                    dataOut;    // fifo head, always visible
    streamBufferPkg::wordCount  wordCount;
    logic                       empty;
    logic                       full;

    // write side only looks at full
    modport guard (
        output writeEn,
        output dataIn,
        input  full
    );

    // read side only looks at empty
    modport reader (
        output readReq,
        input  dataOut,
        input  empty
    );

    modport fifo (
        input  writeEn,
        input  dataIn,
        input  readReq,
        output dataOut,
        output wordCount,
        output empty,
        output full
    );

endinterface

//--- rtl/readStage.sv
module readStage
    import streamBufferPkg::*;
    (
    input   logic       clk,
    input   logic       reset,
    input   logic       readStrobe,
    fifoIf.reader       fifo,
    output  dataWord    outData,
    output  logic       outValid,
    output  eventCount  underflowCount
    );


    logic  readGrant;
    logic  readRefused;


    assign readGrant   = readStrobe && !fifo.empty;
    assign readRefused = readStrobe && fifo.empty;

    // pops the head at the same edge the word is captured
    assign fifo.readReq = readGrant;


    // one cycle valid pulse per granted read
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            outValid <= 1'b0;
        else
            outValid <= readGrant;
    end


    // output word, holds between reads
    always_ff @(posedge clk) begin
        if (readGrant)
            outData <= fifo.dataOut;
    end


    // underflow counter stops at all ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            underflowCount <= '0;
        else if (readRefused && (underflowCount != '1))
            underflowCount <= underflowCount + 1'b1;
    end


endmodule

//--- rtl/simpleDualPortMemory.sv
module simpleDualPortMemory
    #(parameter  DATAWIDTH    = 8,
      parameter  DATADEPTH    = 16,
      localparam ADDRESSWIDTH = $clog2(DATADEPTH))(
    input   logic                      clk,
    input   logic                      writeEn,
    input   logic  [DATAWIDTH-1:0]     dataIn,
    input   logic  [ADDRESSWIDTH-1:0]  writeAddress,
    input   logic  [ADDRESSWIDTH-1:0]  readAddress,
    output  logic  [DATAWIDTH-1:0]     dataOut
    );


    logic  [DATAWIDTH-1:0]  memory [DATADEPTH];


    // write port
    always_ff @(posedge clk) begin
        if (writeEn)
            memory[writeAddress] <= dataIn;
    end


    // read port has no register, head word shows right away
    assign dataOut = memory[readAddress];


endmodule

//--- rtl/singleClockFifo.sv
module singleClockFifo
    #(parameter DATAWIDTH = 8,
      parameter DATADEPTH = 16)(
    input   logic  clk,
    input   logic  reset,
    fifoIf.fifo    fifo
    );


    localparam ADDRESSWIDTH = $clog2(DATADEPTH);

    logic  [ADDRESSWIDTH-1:0]  writePointer;
    logic  [ADDRESSWIDTH-1:0]  readPointer;
    logic  [ADDRESSWIDTH-1:0]  occupancy;
    logic  [DATAWIDTH-1:0]     headWord;


    // one entry stays free, so full sits at depth-1
    assign fifo.empty     = (occupancy == 0);
    assign fifo.full      = (occupancy == ADDRESSWIDTH'(DATADEPTH-1));
    assign fifo.wordCount = occupancy;
    assign fifo.dataOut   = headWord;


    // write pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            writePointer <= '0;
        else if (fifo.writeEn) begin
            if (writePointer == ADDRESSWIDTH'(DATADEPTH-1))
                writePointer <= '0;     // wrap
            else
                writePointer <= writePointer + 1'b1;
        end
    end


    // read pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            readPointer <= '0;
        else if (fifo.readReq) begin
            if (readPointer == ADDRESSWIDTH'(DATADEPTH-1))
                readPointer <= '0;
            else
                readPointer <= readPointer + 1'b1;
        end
    end


    // word counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            occupancy <= '0;
        else if (fifo.readReq && !fifo.writeEn)
            occupancy <= occupancy - 1'b1;  // read only
        else if (fifo.writeEn && !fifo.readReq)
            occupancy <= occupancy + 1'b1;  // write only
        // both or neither leaves the count alone
    end


    // strobes come in already checked against full and empty
    simpleDualPortMemory #(.DATAWIDTH(DATAWIDTH), .DATADEPTH(DATADEPTH))
    memory (
        .clk,
        .writeEn      (fifo.writeEn),
        .dataIn       (fifo.dataIn),
        .writeAddress (writePointer),
        .readAddress  (readPointer),
        .dataOut      (headWord)
    );


endmodule

//--- rtl/streamBuffer.sv
`include "streamBuffer_defs.svh"

module streamBuffer
    import streamBufferPkg::*;
    (
    input   logic       clk,
    input   logic       reset,
    input   logic       writeStrobe,
    input   dataWord    writeData,
    input   logic       readStrobe,
    output  dataWord    outData,
    output  logic       outValid,
    output  wordCount   level,
    output  logic       empty,
    output  logic       full,
    output  eventCount  dropCount,
    output  eventCount  underflowCount
    );


    fifoIf fifoBus ();


    // status straight from the fifo
    assign level = fifoBus.wordCount;
    assign empty = fifoBus.empty;
    assign full  = fifoBus.full;


    writeGuard writeGuard (
        .clk,
        .reset,
        .writeStrobe,
        .writeData,
        .fifo       (fifoBus.guard),
        .dropCount
    );


    singleClockFifo #(
        .DATAWIDTH  (`STREAMBUFFER_DATAWIDTH),
        .DATADEPTH  (`STREAMBUFFER_DEPTH)
    ) singleClockFifo (
        .clk,
        .reset,
        .fifo       (fifoBus.fifo)
    );


    readStage readStage (
        .clk,
        .reset,
        .readStrobe,
        .fifo       (fifoBus.reader),
        .outData,
        .outValid,
        .underflowCount
    );


endmodule

//--- rtl/streamBufferPkg.sv
`include "streamBuffer_defs.svh"

package streamBufferPkg;

    // one byte of the stream
    typedef logic [`STREAMBUFFER_DATAWIDTH-1:0] dataWord;

    // occupancy, same width as a pointer
    typedef logic [`STREAMBUFFER_ADDRWIDTH-1:0] wordCount;

    // saturating event counter
    typedef logic [`STREAMBUFFER_COUNTWIDTH-1:0] eventCount;

endpackage

//--- rtl/writeGuard.sv
module writeGuard
    import streamBufferPkg::*;
    (
    input   logic       clk,
    input   logic       reset,
    input   logic       writeStrobe,
    input   dataWord    writeData,
    fifoIf.guard        fifo,
    output  eventCount  dropCount
    );


    logic  dropHit;


    // full blocks the strobe in the same cycle
    assign fifo.writeEn = writeStrobe && !fifo.full;
    assign fifo.dataIn  = writeData;

    assign dropHit = writeStrobe && fifo.full;


    // saturating drop counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            dropCount <= '0;
        else if (dropHit && (dropCount != '1))
            dropCount <= dropCount + 1'b1;
    end


endmodule

//--- tb/streamBufferTb.sv
`include "streamBuffer_defs.svh"

module streamBufferTb
    import streamBufferPkg::*;
    ();

    localparam int MAXCOUNT = (1 << `STREAMBUFFER_COUNTWIDTH) - 1;
    localparam int CAPACITY = `STREAMBUFFER_DEPTH - 1;   // one entry stays free

    logic       clk;
    logic       reset;
    logic       writeStrobe;
    dataWord    writeData;
    logic       readStrobe;
    dataWord    outData;
    logic       outValid;
    wordCount   level;
    logic       empty;
    logic       full;
    eventCount  dropCount;
    eventCount  underflowCount;

    // stimulus table, one entry per cycle
    int       rowTest[$];
    logic     rowWrite[$];
    dataWord  rowData[$];
    logic     rowRead[$];
    string    testName [1:6];

    // reference model state
    dataWord  modelQueue[$];
    logic     expValid;
    dataWord  expData;
    logic     haveData;         // outData is unknown until the first read
    int       expDrop;
    int       expUnder;

    int  errorCount;
    int  testErrors;
    int  testsOk;
    int  testsBad;
    int  cycleCount;
    int  cycleLimit;
    int  seedValue;

    streamBuffer UUT (
        .clk,
        .reset,
        .writeStrobe,
        .writeData,
        .readStrobe,
        .outData,
        .outValid,
        .level,
        .empty,
        .full,
        .dropCount,
        .underflowCount
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run limit, set once the table is built
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic addRow(input int test, input logic ws, input dataWord wd, input logic rs);
        rowTest.push_back(test);
        rowWrite.push_back(ws);
        rowData.push_back(wd);
        rowRead.push_back(rs);
    endtask

    task automatic writeWords(input int test, input int n);
        for (int k = 0; k < n; k++)
            addRow(test, 1'b1, dataWord'($urandom_range(255)), 1'b0);
    endtask

    task automatic readWords(input int test, input int n);
        for (int k = 0; k < n; k++)
            addRow(test, 1'b0, '0, 1'b1);
    endtask

    task automatic bothStrobes(input int test, input int n);
        for (int k = 0; k < n; k++)
            addRow(test, 1'b1, dataWord'($urandom_range(255)), 1'b1);
    endtask

    task automatic idleRows(input int test, input int n);
        for (int k = 0; k < n; k++)
            addRow(test, 1'b0, '0, 1'b0);
    endtask

    task automatic driveInputs(input logic ws, input dataWord wd, input logic rs);
        writeStrobe <= ws;
        writeData   <= wd;
        readStrobe  <= rs;
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail time=%0t signal=%s actual=%0h expected=%0h",
                     $time, name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    // acceptance rules, evaluated on the state before the edge
    task automatic updateModel(input logic ws, input dataWord wd, input logic rs);
        logic wasEmpty;
        logic wasFull;
        wasEmpty = (modelQueue.size() == 0);
        wasFull  = (modelQueue.size() == CAPACITY);
        expValid = rs && !wasEmpty;
        if (expValid) begin
            expData  = modelQueue.pop_front();
            haveData = 1'b1;
        end
        if (rs && wasEmpty && expUnder < MAXCOUNT)
            expUnder++;
        if (ws && wasFull) begin
            if (expDrop < MAXCOUNT)
                expDrop++;
        end else if (ws) begin
            modelQueue.push_back(wd);
        end
    endtask

    task automatic checkOutputs();
        compareValue("level", level, modelQueue.size());
        compareValue("empty", empty, modelQueue.size() == 0);
        compareValue("full", full, modelQueue.size() == CAPACITY);
        compareValue("outValid", outValid, expValid);
        if (haveData)
            compareValue("outData", outData, expData);
        compareValue("dropCount", dropCount, expDrop);
        compareValue("underflowCount", underflowCount, expUnder);
    endtask

    task automatic reportTest(input int test);
        if (testErrors == 0) begin
            $display("test %0d %s: ok", test, testName[test]);
            testsOk++;
        end else begin
            $display("test %0d %s: %0d mismatches", test, testName[test], testErrors);
            testsBad++;
        end
        testErrors = 0;
    endtask

    initial begin
        int rows;
        seedValue = $urandom(10);
        reset       = 1'b1;
        writeStrobe = 1'b0;
        writeData   = '0;
        readStrobe  = 1'b0;
        expValid    = 1'b0;
        expData     = '0;
        haveData    = 1'b0;
        expDrop     = 0;
        expUnder    = 0;
        errorCount  = 0;
        testErrors  = 0;
        testsOk     = 0;
        testsBad    = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        testName[1] = "reset state";
        testName[2] = "ordered transfer";
        testName[3] = "full and drop";
        testName[4] = "empty and underflow";
        testName[5] = "simultaneous strobes";
        testName[6] = "pointer wraparound";

        idleRows(1, 2);
        writeWords(2, 10);
        readWords(2, 10);
        idleRows(2, 1);
        writeWords(3, CAPACITY);
        writeWords(3, 3);               // all three dropped
        writeWords(3, MAXCOUNT);        // drop counter runs into its ceiling
        readWords(3, CAPACITY);
        idleRows(3, 1);
        readWords(4, MAXCOUNT + 3);     // underflow counter stops at its ceiling
        idleRows(4, 1);
        writeWords(5, 5);
        bothStrobes(5, 6);
        readWords(5, 5);
        idleRows(5, 1);
        bothStrobes(5, 1);              // empty, read refused
        readWords(5, 1);
        writeWords(5, CAPACITY);
        bothStrobes(5, 1);              // full, write dropped
        readWords(5, CAPACITY - 1);
        idleRows(5, 1);
        writeWords(6, 3);
        bothStrobes(6, 36);             // pointers go round more than twice
        readWords(6, 3);
        idleRows(6, 1);

        rows = rowTest.size();
        cycleLimit = rows + 16 + 50;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        driveInputs(rowWrite[0], rowData[0], rowRead[0]);
        for (int i = 0; i < rows; i++) begin
            @(posedge clk);             // row i sampled here
            if (i + 1 < rows)
                driveInputs(rowWrite[i+1], rowData[i+1], rowRead[i+1]);
            else
                driveInputs(1'b0, '0, 1'b0);
            @(negedge clk);
            updateModel(rowWrite[i], rowData[i], rowRead[i]);
            checkOutputs();
            if (i == rows - 1 || rowTest[i+1] != rowTest[i])
                reportTest(rowTest[i]);
        end

        $display("tests ok: %0d, tests with errors: %0d, value mismatches: %0d",
                 testsOk, testsBad, errorCount);
        if (errorCount == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
